// ==== rtl/fp_fwd_pkg.sv ====
// Shared widths, vector typedefs, the forwarding source enum and pipeline stage structs
`default_nettype none

package fp_fwd_pkg;

  // ============================================================
  // Widths
  // ============================================================

  // Single-precision FP register file, one word per register
  localparam int unsigned FLEN = 32;

  // f0..f31, and f0 is an ordinary register here
  localparam int unsigned FP_REG_IDX_W = 5;

  // Three sources cover the fused multiply-add forms (fs1, fs2, fs3)
  localparam int unsigned MAX_SRCS = 3;

  // ============================================================
  // Vector types
  // ============================================================

  // One FP register value
  typedef logic [FLEN-1:0] fp_data_t;

  // One FP register number
  typedef logic [FP_REG_IDX_W-1:0] fp_reg_idx_t;

  // Where a forwarded operand comes from, highest priority first
  typedef enum logic [1:0] {
    FWD_LOAD = 2'd0,
    FWD_MA   = 2'd1,
    FWD_WB   = 2'd2,
    FWD_RF   = 2'd3
  } fwd_src_e;

  // ============================================================
  // Stage bundles
  // ============================================================

  // Pipeline control, load_use_stall is a subset of stall
  typedef struct packed {
    logic stall;
    logic load_use_stall;
  } pipe_ctrl_t;

  // Producer currently sitting in MA
  typedef struct packed {
    logic        fp_we;
    logic        is_fp_load;
    fp_reg_idx_t dest;
  } ma_stage_t;

  // Producer in WB, with the value that is about to be written
  typedef struct packed {
    logic        fp_we;
    fp_reg_idx_t dest;
    fp_data_t    data;
  } wb_stage_t;

  // One consumer source of the instruction in EX
  // The rf_data field was read from the register file in ID
  typedef struct packed {
    fp_reg_idx_t idx;
    fp_data_t    rf_data;
  } ex_src_t;

endpackage : fp_fwd_pkg

`default_nettype wire

// ==== rtl/fp_ma_data_capture.sv ====
// MA forward-data register, load-use stall flag and the choice of load forward data
`timescale 1ns/1ps
`default_nettype none

module fp_ma_data_capture (
  input  wire                    i_clk,
  input  wire                    i_rst_n,
  // Pipeline stall controls
  input  fp_fwd_pkg::pipe_ctrl_t i_pipe_ctrl,
  // The instruction in MA is an FP load
  input  wire                    i_ma_is_fp_load,
  // Compute result of the instruction in EX
  input  fp_fwd_pkg::fp_data_t   i_ex_fp_result,
  // Read data of the load in MA
  input  fp_fwd_pkg::fp_data_t   i_mem_rdata,
  output fp_fwd_pkg::fp_data_t   o_ma_fwd_data,
  output fp_fwd_pkg::fp_data_t   o_load_fwd_data
);

  import fp_fwd_pkg::*;

  // Value that the MA stage forwards back to EX
  fp_data_t ma_fwd_q;

  // Set in the cycle after a load-use stall cycle
  logic load_use_q;

  // True while the captured load data must stand in for the live read data
  logic use_load_capture;

  // ============================================================
  // MA data register
  // ============================================================

  // A load-use stall on an FP load takes the memory data, so the
  // dependent instruction sees the same value for the whole stall
  // Otherwise the EX result follows the instruction into MA on
  // every unstalled edge, and a plain stall keeps the old value
  always_ff @(posedge i_clk) begin
    if (i_pipe_ctrl.load_use_stall && i_ma_is_fp_load) begin
      ma_fwd_q <= i_mem_rdata;
    end else if (!i_pipe_ctrl.stall) begin
      ma_fwd_q <= i_ex_fp_result;
    end
  end

  // ============================================================
  // Load-use flag
  // ============================================================

  // Stretches the stall by one cycle, covering the cycle where the
  // consumer leaves the stall but the load is still visible in MA
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      load_use_q <= 1'b0;
    end else begin
      load_use_q <= i_pipe_ctrl.load_use_stall;
    end
  end

  assign use_load_capture = i_pipe_ctrl.load_use_stall || load_use_q;

  // Load forward data comes from the capture register around a
  // load-use stall, and from the live read data at any other time
  assign o_load_fwd_data = use_load_capture ? ma_fwd_q : i_mem_rdata;
  assign o_ma_fwd_data   = ma_fwd_q;

  // A load-use stall is one kind of stall, so stall must be set too
  a_load_use_is_stall : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_pipe_ctrl.load_use_stall |-> i_pipe_ctrl.stall
  ) else $error("load_use_stall asserted without stall");

endmodule : fp_ma_data_capture

`default_nettype wire

// ==== rtl/fp_operand_select.sv ====
// Hazard compare and priority mux for one FP source operand of the instruction in EX
`timescale 1ns/1ps
`default_nettype none

module fp_operand_select (
  // Producer in MA
  input  fp_fwd_pkg::ma_stage_t i_ma_stage,
  // Producer in WB, carrying its write data
  input  fp_fwd_pkg::wb_stage_t i_wb_stage,
  // The source this instance serves
  input  fp_fwd_pkg::ex_src_t   i_ex_src,
  // Registered compute result of the instruction in MA
  input  fp_fwd_pkg::fp_data_t  i_ma_fwd_data,
  // Load data for the FP load in MA, live or captured
  input  fp_fwd_pkg::fp_data_t  i_load_fwd_data,
  output fp_fwd_pkg::fp_data_t  o_fwd_data
);

  import fp_fwd_pkg::*;

  // Index compares against each producer stage
  logic ma_idx_hit;
  logic wb_idx_hit;

  // Qualified hits, each needs the matching stage to actually write
  logic load_hit;
  logic ma_hit;
  logic wb_hit;

  // Selected source for this operand
  fwd_src_e fwd_src;

  // ============================================================
  // Hazard detection
  // ============================================================

  // No hardwired zero register, f0 takes part like any other index
  assign ma_idx_hit = (i_ma_stage.dest == i_ex_src.idx);
  assign wb_idx_hit = (i_wb_stage.dest == i_ex_src.idx);

  assign load_hit = ma_idx_hit && i_ma_stage.is_fp_load;
  assign ma_hit   = ma_idx_hit && i_ma_stage.fp_we;
  assign wb_hit   = wb_idx_hit && i_wb_stage.fp_we;

  // The youngest producer wins, and within MA a load wins over the
  // compute path because its data is not in the MA data register
  always_comb begin
    if (load_hit) begin
      fwd_src = FWD_LOAD;
    end else if (ma_hit) begin
      fwd_src = FWD_MA;
    end else if (wb_hit) begin
      fwd_src = FWD_WB;
    end else begin
      fwd_src = FWD_RF;
    end
  end

  // ============================================================
  // Operand mux
  // ============================================================

  always_comb begin
    unique case (fwd_src)
      FWD_LOAD: o_fwd_data = i_load_fwd_data;
      FWD_MA:   o_fwd_data = i_ma_fwd_data;
      FWD_WB:   o_fwd_data = i_wb_stage.data;
      default:  o_fwd_data = i_ex_src.rf_data;
    endcase
  end

  // An unknown hazard flag falls silently through the if chain above
  // and lands on a legal but wrong select, which would happen if a
  // stage control bit or index were left undriven upstream
  always_comb begin
    a_fwd_src_legal : assert (!$isunknown({load_hit, ma_hit, wb_hit}))
      else $error("forward select %s built from unknown hazard flags %b",
                  fwd_src.name(), {load_hit, ma_hit, wb_hit});
  end

endmodule : fp_operand_select

`default_nettype wire

// ==== rtl/fp_forwarding_unit.sv ====
// FP operand forwarding top level with one MA data capture and one select per source
`timescale 1ns/1ps
`default_nettype none

module fp_forwarding_unit #(
  // Number of FP sources of the EX instruction, 3 with FMA and 2 without
  parameter int unsigned NUM_SRCS = 3
) (
  input  wire                                   i_clk,
  input  wire                                   i_rst_n,
  // Stall controls from the hazard unit
  input  fp_fwd_pkg::pipe_ctrl_t                i_pipe_ctrl,
  // Compute result of the instruction in EX
  input  fp_fwd_pkg::fp_data_t                  i_ex_fp_result,
  // Producer in MA and its load read data
  input  fp_fwd_pkg::ma_stage_t                 i_ma_stage,
  input  fp_fwd_pkg::fp_data_t                  i_mem_rdata,
  // Producer in WB
  input  fp_fwd_pkg::wb_stage_t                 i_wb_stage,
  // Source indices and register-file values of the EX instruction
  input  fp_fwd_pkg::ex_src_t  [NUM_SRCS-1:0]   i_ex_srcs,
  // Resolved operand values for the FPU
  output fp_fwd_pkg::fp_data_t [NUM_SRCS-1:0]   o_fwd_data
);

  import fp_fwd_pkg::*;

  // Shared by every operand select
  fp_data_t ma_fwd_data;
  fp_data_t load_fwd_data;

  // Reject a source count the pipeline cannot have
  if (NUM_SRCS < 1 || NUM_SRCS > MAX_SRCS) begin : g_bad_num_srcs
    $error("NUM_SRCS must lie between 1 and %0d", MAX_SRCS);
  end

  // ============================================================
  // MA data capture
  // ============================================================

  // One register serves all sources, since MA holds a single producer
  fp_ma_data_capture u_ma_capture (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_pipe_ctrl     (i_pipe_ctrl),
    .i_ma_is_fp_load (i_ma_stage.is_fp_load),
    .i_ex_fp_result  (i_ex_fp_result),
    .i_mem_rdata     (i_mem_rdata),
    .o_ma_fwd_data   (ma_fwd_data),
    .o_load_fwd_data (load_fwd_data)
  );

  // ============================================================
  // Per-source operand select
  // ============================================================

  for (genvar i = 0; i < NUM_SRCS; i++) begin : g_src
    fp_operand_select u_sel (
      .i_ma_stage      (i_ma_stage),
      .i_wb_stage      (i_wb_stage),
      .i_ex_src        (i_ex_srcs[i]),
      .i_ma_fwd_data   (ma_fwd_data),
      .i_load_fwd_data (load_fwd_data),
      .o_fwd_data      (o_fwd_data[i])
    );
  end

  // A load in MA must not also claim the compute path, otherwise the
  // select would see two MA producers for the same register
  a_load_not_compute : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_ma_stage.is_fp_load |-> !i_ma_stage.fp_we
  ) else $error("FP load in MA with fp_we set");

endmodule : fp_forwarding_unit

`default_nettype wire

// ==== dv/tb_fp_forwarding_unit.sv ====
// Self-checking testbench for the FP forwarding unit, driven from a stimulus file
`timescale 1ns/1ps
`default_nettype none

module tb_fp_forwarding_unit;

  import fp_fwd_pkg::*;

  // ============================================================
  // Test constants
  // ============================================================

  localparam int NUM_SRCS     = 3;
  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;
  // Inputs change shortly after the rising edge, outputs are sampled just before the next one
  localparam int DRIVE_DELAY  = 1;
  localparam int CHECK_DELAY  = CLK_PERIOD - 1;

  // Stimulus file layout, one vector of 11 words per cycle
  localparam string STIM_FILE     = "dv/fp_fwd_stimulus.txt";
  localparam int    NUM_VECTORS   = 16;
  localparam int    WORDS_PER_VEC = 11;
  localparam int    STIM_DEPTH    = 256;

  // Word offsets inside one vector
  localparam int W_CTRL = 0;
  localparam int W_IDX  = 1;
  localparam int W_EX   = 2;
  localparam int W_MEM  = 3;
  localparam int W_WB   = 4;
  localparam int W_RF   = 5;
  localparam int W_EXP  = 8;

  // Every vector takes one cycle, plus reset and some slack
  localparam int TIMEOUT_CYCLES = NUM_VECTORS + RESET_CYCLES + 20;

  typedef logic [7:0] stim_addr_t;

  // DUT connections
  logic                    i_clk;
  logic                    i_rst_n;
  pipe_ctrl_t              i_pipe_ctrl;
  fp_data_t                i_ex_fp_result;
  ma_stage_t               i_ma_stage;
  fp_data_t                i_mem_rdata;
  wb_stage_t               i_wb_stage;
  ex_src_t  [NUM_SRCS-1:0] i_ex_srcs;
  fp_data_t [NUM_SRCS-1:0] o_fwd_data;

  logic [31:0] stim_mem [STIM_DEPTH];
  int          cycle_count = 0;

  fp_forwarding_unit #(
    .NUM_SRCS (NUM_SRCS)
  ) dut_i (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_pipe_ctrl    (i_pipe_ctrl),
    .i_ex_fp_result (i_ex_fp_result),
    .i_ma_stage     (i_ma_stage),
    .i_mem_rdata    (i_mem_rdata),
    .i_wb_stage     (i_wb_stage),
    .i_ex_srcs      (i_ex_srcs),
    .o_fwd_data     (o_fwd_data)
  );

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  // Guards against a run that never reaches its end
  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  // ============================================================
  // Stimulus access and checks
  // ============================================================

  function automatic logic [31:0] vector_word(input int vec, input int offset);
    return stim_mem[stim_addr_t'(vec * WORDS_PER_VEC + offset)];
  endfunction

  task automatic init_inputs();
    i_clk          = 1'b0;
    i_rst_n        = 1'b0;
    i_pipe_ctrl    = '0;
    i_ex_fp_result = '0;
    i_ma_stage     = '0;
    i_mem_rdata    = '0;
    i_wb_stage     = '0;
    i_ex_srcs      = '0;
  endtask

  // Unused words keep an address-based pattern, so a short file shows up in the last word
  task automatic load_stimulus();
    stim_addr_t last;
    last = stim_addr_t'(NUM_VECTORS * WORDS_PER_VEC - 1);
    for (int a = 0; a < STIM_DEPTH; a++) begin
      stim_mem[stim_addr_t'(a)] = 32'hbad0_0000 | 32'(a);
    end
    $readmemh(STIM_FILE, stim_mem);
    if (stim_mem[last] == (32'hbad0_0000 | 32'(last))) begin
      $display("stimulus file %s holds fewer than %0d vectors", STIM_FILE, NUM_VECTORS);
      $display("TEST FAILED");
      $fatal(1, "no usable stimulus");
    end
  endtask

  // Control word is one hex digit per flag and a byte for the MA destination
  task automatic drive_vector(input int vec);
    logic [31:0] ctrl_w;
    logic [31:0] idx_w;
    ctrl_w = vector_word(vec, W_CTRL);
    idx_w  = vector_word(vec, W_IDX);
    i_pipe_ctrl.stall          = ctrl_w[28];
    i_pipe_ctrl.load_use_stall = ctrl_w[24];
    i_ma_stage.fp_we           = ctrl_w[20];
    i_ma_stage.is_fp_load      = ctrl_w[16];
    i_ma_stage.dest            = ctrl_w[12:8];
    i_wb_stage.fp_we           = ctrl_w[4];
    i_wb_stage.dest            = idx_w[28:24];
    i_wb_stage.data            = vector_word(vec, W_WB);
    i_ex_fp_result             = vector_word(vec, W_EX);
    i_mem_rdata                = vector_word(vec, W_MEM);
    // One index byte per source, fs1 first
    i_ex_srcs[0].idx     = idx_w[20:16];
    i_ex_srcs[1].idx     = idx_w[12:8];
    i_ex_srcs[2].idx     = idx_w[4:0];
    i_ex_srcs[0].rf_data = vector_word(vec, W_RF);
    i_ex_srcs[1].rf_data = vector_word(vec, W_RF + 1);
    i_ex_srcs[2].rf_data = vector_word(vec, W_RF + 2);
  endtask

  task automatic compare_value(input int vec, input int operand,
                               input fp_data_t actual, input fp_data_t wanted);
    if (actual !== wanted) begin
      $display("mismatch at time %0t: vector %0d operand %0d got %08h expected %08h",
               $time, vec, operand, actual, wanted);
      $display("TEST FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic check_outputs(input int vec);
    compare_value(vec, 0, o_fwd_data[0], vector_word(vec, W_EXP));
    compare_value(vec, 1, o_fwd_data[1], vector_word(vec, W_EXP + 1));
    compare_value(vec, 2, o_fwd_data[2], vector_word(vec, W_EXP + 2));
  endtask

  // ============================================================
  // Main sequence
  // ============================================================

  initial begin
    init_inputs();
    load_stimulus();
    repeat (RESET_CYCLES) @(posedge i_clk);
    #(DRIVE_DELAY);
    i_rst_n = 1'b1;
    // One vector per cycle, the MA register state carries from vector to vector
    for (int v = 0; v < NUM_VECTORS; v++) begin
      drive_vector(v);
      #(CHECK_DELAY - DRIVE_DELAY);
      check_outputs(v);
      @(posedge i_clk);
      #(DRIVE_DELAY);
    end
    // Any mismatch has already stopped the run
    $display("TEST OK");
    $finish;
  end

endmodule : tb_fp_forwarding_unit

`default_nettype wire

// ==== filelist.f ====
rtl/fp_fwd_pkg.sv
rtl/fp_ma_data_capture.sv
rtl/fp_operand_select.sv
rtl/fp_forwarding_unit.sv
dv/tb_fp_forwarding_unit.sv

// ==== Makefile ====
# Verilator build and run for the FP forwarding unit testbench

VERILATOR ?= verilator
TOP       ?= tb_fp_forwarding_unit
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
STIM      ?= dv/fp_fwd_stimulus.txt
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= TEST FAILED
PASS_MSG  ?= TEST OK

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The binary exits nonzero on $$fatal, so the log decides the result
run: $(SIM_BIN) $(STIM)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/fp_fwd_stimulus.txt ====
// Columns: ctrl idx ex_result mem_rdata wb_data rf0 rf1 rf2 exp0 exp1 exp2
// ctrl digits: stall load_use ma_we ma_load ma_dest(2) wb_we 0; idx bytes: wb_dest src0 src1 src2
// No hazard, f0 included, MA dest matches but nothing writes
00000000 00000102 11110000 22220000 33330000 0a000000 0a000001 0a000002 0a000000 0a000001 0a000002
00000000 0503041f 11110001 22220001 33330001 0a000010 0a000011 0a000012 0a000010 0a000011 0a000012
// MA compute wins over WB on all sources, then a mix with f0 in MA
00100710 07070707 11110002 22220002 33330002 0a000020 0a000021 0a000022 11110001 11110001 11110001
00100010 05000506 11110003 22220003 33330003 0a000030 0a000031 0a000032 11110002 33330003 0a000032
// WB only, one source misses
00000910 09090a09 11110004 22220004 33330004 0a000040 0a000041 0a000042 33330004 0a000041 33330004
// FP load in MA without stall forwards the live read data
00010c10 0c0c0d0c 11110005 44440005 33330005 0a000050 0a000051 0a000052 44440005 0a000051 44440005
// Load-use stall, first cycle shows the MA register, then the captured load data
11010e00 000e0e01 11110006 55550006 33330006 0a000060 0a000061 0a000062 11110005 11110005 0a000062
11010e00 000e0e01 11110007 66660007 33330007 0a000070 0a000071 0a000072 55550006 55550006 0a000072
// Cycle after the stall keeps the capture, then the live data returns
00010e00 000e010e 11110008 77770008 33330008 0a000080 0a000081 0a000082 66660007 0a000081 66660007
00010e00 000e0e0e 11110009 88880009 33330009 0a000090 0a000091 0a000092 88880009 88880009 88880009
// Stall hold with a changing EX result, release picks up the new value
10100310 03030303 1111000a 2222000a 3333000a 0a0000a0 0a0000a1 0a0000a2 11110009 11110009 11110009
10100310 03030303 1111000b 2222000b 3333000b 0a0000b0 0a0000b1 0a0000b2 11110009 11110009 11110009
00100310 03030303 1111000c 2222000c 3333000c 0a0000c0 0a0000c1 0a0000c2 11110009 11110009 11110009
00100310 03030303 1111000d 2222000d 3333000d 0a0000d0 0a0000d1 0a0000d2 1111000c 1111000c 1111000c
// Back to no hazard, then WB, MA and RF on one instruction
00000000 001f1000 1111000e 2222000e 3333000e 0a0000e0 0a0000e1 0a0000e2 0a0000e0 0a0000e1 0a0000e2
00101010 1f1f1011 1111000f 2222000f 3333000f 0a0000f0 0a0000f1 0a0000f2 3333000f 1111000e 0a0000f2
